// ==== files.f ====
hdl/axi_mem_pkg.sv
hdl/axi_burst_addr.sv
hdl/axi_ram_array.sv
hdl/axi_wr_ctrl.sv
hdl/axi_rd_ctrl.sv
hdl/axi_ram.sv
bench/axi_ram_chk.sv
bench/tb_clkgen.sv
bench/tb_axi_ram.sv

// ==== Makefile ====
TOP := tb_axi_ram

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall --top-module axi_ram -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_axi_ram.sv ====
`timescale 1ns/10ps

module tb_axi_ram import axi_mem_pkg::*; ();

    localparam int mem_bytes   = 4096;
    // Upper bound on beats over all tests
    localparam int total_beats = 1024 + 16 + 12 * 32 + 80 + 60 + 24 + 10 * 32;

    logic        clk;
    logic        rst_n;
    axi_aw_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    axi_b_t      b;
    logic        b_valid;
    logic        b_ready;
    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;

    logic [7:0]  model_mem [mem_bytes];
    logic [31:0] wr_data [256];
    logic [3:0]  wr_strb [256];
    axi_r_t      rd_beat [256];
    int          rd_count;
    axi_b_t      b_got;
    logic        bp;            // Random stalls on W, B and R
    int          errors;
    int          checks;
    int          test_errors;
    int          test_checks;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    axi_ram #(.mem_addr_w(12)) u_axi_ram (
        .clk(clk), .rst_n(rst_n),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    bind axi_ram axi_ram_chk u_chk (
        .clk(clk), .rst_n(rst_n), .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    initial begin
        repeat (total_beats * 20 + 2000) @(posedge clk);
        $display("Timeout: an AXI handshake did not complete in time");
        $display("Done: errors found");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        test_checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("Error: %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    function automatic logic burst_legal(input logic [7:0] len, input logic [2:0] size,
                                         input burst_e burst);
        if (size > 3'd2) return 1'b0;
        if (burst == burst_wrap) return (len == 8'd1 || len == 8'd3 || len == 8'd7 || len == 8'd15);
        return 1'b1;
    endfunction

    // Address of beat n, straight from the AXI burst equations
    function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [7:0] len,
                                              input logic [2:0] size, input burst_e burst,
                                              input int n);
        logic [31:0] nb;
        logic [31:0] wrap_bytes;
        logic [31:0] lower;
        logic [31:0] a;
        nb         = 32'd1 << size;
        wrap_bytes = nb * (32'(len) + 32'd1);
        lower      = (start / wrap_bytes) * wrap_bytes;
        if (burst == burst_fixed || n == 0) return start;
        a = (start / nb) * nb + nb * 32'(n);
        if (burst == burst_wrap && a >= lower + wrap_bytes) a = a - wrap_bytes;
        return a;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        int base;
        base = int'(a[11:2]) * 4;
        return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    endfunction

    function automatic resp_e model_write(input logic [31:0] addr, input logic [7:0] len,
                                          input logic [2:0] size, input burst_e burst);
        logic [31:0] a;
        int          nb;
        int          lo;
        int          base;
        logic        ok;
        resp_e       resp;
        ok   = burst_legal(len, size, burst);
        resp = ok ? resp_okay : resp_slverr;
        nb   = 1 << size;
        for (int i = 0; i <= int'(len); i++) begin
            a = beat_addr(addr, len, size, burst, i);
            if (a >= 32'(mem_bytes)) begin
                resp = resp_slverr;
            end else if (ok) begin
                lo   = int'(a[1:0]);
                base = int'(a[11:2]) * 4;
                for (int k = lo; k < (lo / nb) * nb + nb; k++) begin  // Start byte to unit end
                    if (wr_strb[i][k]) model_mem[base + k] = wr_data[i][8*k +: 8];
                end
            end
        end
        return resp;
    endfunction

    task automatic fill_beats(input logic rand_strb);
        for (int i = 0; i < 256; i++) begin
            wr_data[i] = $urandom;
            wr_strb[i] = rand_strb ? 4'($urandom) : 4'hf;
        end
    endtask

    task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                               input logic [2:0] size, input burst_e burst);
        logic done;
        @(posedge clk);
        aw       <= '{id: id, addr: addr, len: len, size: size, burst: burst};
        aw_valid <= 1'b1;
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        @(posedge clk);
        aw_valid <= 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            while (bp && $urandom_range(3) == 0) begin
                w_valid <= 1'b0;
                @(posedge clk);
            end
            w       <= '{data: wr_data[i], strb: wr_strb[i], last: (i == int'(len))};
            w_valid <= 1'b1;
            @(negedge clk);
            while (!w_ready) @(negedge clk);
            @(posedge clk);
        end
        w_valid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            b_ready <= bp ? 1'($urandom) : 1'b1;
            @(negedge clk);
            if (b_valid && b_ready) begin
                b_got = b;
                done  = 1'b1;
            end
            @(posedge clk);
        end
        b_ready <= 1'b0;
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                              input logic [2:0] size, input burst_e burst);
        logic done;
        @(posedge clk);
        ar       <= '{id: id, addr: addr, len: len, size: size, burst: burst};
        ar_valid <= 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        ar_valid <= 1'b0;
        done     = 1'b0;
        rd_count = 0;
        while (!done) begin
            r_ready <= bp ? 1'($urandom) : 1'b1;
            @(negedge clk);
            if (r_valid && r_ready) begin
                rd_beat[rd_count] = r;
                rd_count++;
                done = r.last || rd_count > int'(len);
            end
            @(posedge clk);
        end
        r_ready <= 1'b0;
    endtask

    task automatic write_check(input string name, input logic [3:0] id, input logic [31:0] addr,
                               input logic [7:0] len, input logic [2:0] size, input burst_e burst);
        write_burst(id, addr, len, size, burst);
        check({name, " b.resp"}, 32'(model_write(addr, len, size, burst)), 32'(b_got.resp));
        check({name, " b.id"}, 32'(id), 32'(b_got.id));
    endtask

    task automatic read_check(input string name, input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size, input burst_e burst);
        logic [31:0] a;
        logic        good;
        read_burst(id, addr, len, size, burst);
        check({name, " beat count"}, 32'(len) + 32'd1, 32'(rd_count));
        for (int i = 0; i < rd_count; i++) begin
            a    = beat_addr(addr, len, size, burst, i);
            good = burst_legal(len, size, burst) && a < 32'(mem_bytes);
            check($sformatf("%s r.data[%0d]", name, i), good ? model_word(a) : 32'd0,
                  rd_beat[i].data);
            check($sformatf("%s r.resp[%0d]", name, i), 32'(good ? resp_okay : resp_slverr),
                  32'(rd_beat[i].resp));
            check($sformatf("%s r.last[%0d]", name, i), 32'(i == int'(len)), 32'(rd_beat[i].last));
            check($sformatf("%s r.id[%0d]", name, i), 32'(id), 32'(rd_beat[i].id));
        end
    endtask

    task automatic xfer(input string name, input logic [3:0] id, input logic [31:0] addr,
                        input logic [7:0] len, input logic [2:0] size, input burst_e burst);
        write_check(name, id, addr, len, size, burst);
        read_check(name, id, addr, len, size, burst);
    endtask

    initial begin
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        burst_e      burst;
        void'($urandom(31));
        aw          = '0;
        w           = '0;
        ar          = '0;
        aw_valid    = 1'b0;
        w_valid     = 1'b0;
        b_ready     = 1'b0;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        bp          = 1'b0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        test_checks = 0;
        wait (rst_n === 1'b1);

        for (int base = 0; base < mem_bytes; base += 64) begin  // Known contents everywhere
            fill_beats(1'b0);
            write_check("preload", 4'(base / 64), 32'(base), 8'd15, 3'd2, burst_incr);
        end
        end_test("preload");

        for (int i = 0; i < 8; i++) begin
            fill_beats(1'b0);
            xfer("single", 4'($urandom), 32'($urandom_range(1023)) * 4, 8'd0, 3'd2, burst_incr);
        end
        end_test("single");

        for (int i = 0; i < 12; i++) begin
            fill_beats(1'b1);
            len  = 8'($urandom_range(15));
            addr = 32'($urandom_range(1023 - int'(len))) * 4;
            xfer("incr", 4'($urandom), addr, len, 3'd2, burst_incr);
        end
        end_test("incr");

        for (int i = 0; i < 4; i++) begin
            fill_beats(1'b1);
            len  = 8'((2 << i) - 1);
            size = 3'($urandom_range(2));
            xfer("wrap", 4'($urandom), 32'($urandom_range(4000)) | 32'd1, len, size, burst_wrap);
        end
        fill_beats(1'b0);
        addr = 32'($urandom_range(1000)) * 4;
        write_check("wrap len 3", 4'ha, addr, 8'd2, 3'd2, burst_wrap);
        read_check("wrap len 3", 4'ha, addr, 8'd2, 3'd2, burst_wrap);
        read_check("wrap len 3", 4'hb, addr, 8'd3, 3'd2, burst_incr);
        end_test("wrap");

        fill_beats(1'b1);
        addr = 32'($urandom_range(1023)) * 4;
        xfer("fixed", 4'h3, addr, 8'd3, 3'd2, burst_fixed);
        read_check("fixed", 4'h4, addr, 8'd0, 3'd2, burst_incr);
        for (int s = 0; s < 2; s++) begin
            fill_beats(1'b1);
            xfer("narrow", 4'($urandom), 32'($urandom_range(4000)), 8'd7, 3'(s), burst_incr);
        end
        fill_beats(1'b1);
        xfer("narrow fixed", 4'h5, 32'($urandom_range(4000)), 8'd3, 3'd1, burst_fixed);
        fill_beats(1'b0);
        xfer("size 3", 4'h6, 32'($urandom_range(1023)) * 4, 8'd1, 3'd3, burst_incr);
        end_test("fixed_narrow");

        fill_beats(1'b0);
        addr = 32'h1000 + 32'($urandom_range(255)) * 4;
        write_check("range", 4'h7, addr, 8'd3, 3'd2, burst_incr);
        read_check("range", 4'h8, addr, 8'd3, 3'd2, burst_incr);
        read_check("range alias", 4'h9, addr - 32'h1000, 8'd3, 3'd2, burst_incr);
        xfer("range edge", 4'hc, 32'd4088, 8'd3, 3'd2, burst_incr);  // Two beats in, two out
        end_test("range");

        bp = 1'b1;
        for (int i = 0; i < 10; i++) begin
            fill_beats(1'b1);
            burst = burst_e'($urandom_range(2));
            size  = 3'($urandom_range(2));
            len   = (burst == burst_wrap) ? 8'((2 << $urandom_range(3)) - 1)
                                          : 8'($urandom_range(15));
            xfer("backpressure", 4'($urandom), 32'($urandom_range(4000)), len, size, burst);
        end
        end_test("backpressure");

        if (u_axi_ram.u_chk.fails != 0) begin
            $display("Protocol assertions failed %0d times", u_axi_ram.u_chk.fails);
        end
        $display("Summary: %0d checks, %0d errors", checks, errors + u_axi_ram.u_chk.fails);
        if (errors == 0 && u_axi_ram.u_chk.fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;  // Released on the last reset edge
    end

endmodule

// ==== bench/axi_ram_chk.sv ====
`timescale 1ns/10ps

module axi_ram_chk import axi_mem_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input axi_b_t b,
    input logic   b_valid,
    input logic   b_ready,
    input axi_r_t r,
    input logic   r_valid,
    input logic   r_ready
);

    int fails = 0;

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
        fails++;
        $error("B response withdrawn or changed before b_ready");
    end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
        fails++;
        $error("R beat withdrawn or changed before r_ready");
    end

    // Last flag never shows on an idle R channel
    r_last_valid: assert property (@(posedge clk) disable iff (!rst_n) r.last |-> r_valid)
    else begin
        fails++;
        $error("r.last high without r_valid");
    end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !b_valid && !r_valid)
    else begin
        fails++;
        $error("b_valid or r_valid high during reset");
    end

endmodule

// ==== hdl/axi_ram.sv ====
`timescale 1ns/10ps

module axi_ram import axi_mem_pkg::*; #(
    parameter int mem_addr_w = 12  // log2 of memory bytes
) (
    input  logic    clk,
    input  logic    rst_n,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready
);

    logic                  mem_we;
    logic [mem_addr_w-3:0] mem_waddr;
    logic [axi_data_w-1:0] mem_wdata;
    logic [axi_strb_w-1:0] mem_wstrb;
    logic                  mem_re;
    logic [mem_addr_w-3:0] mem_raddr;
    logic [axi_data_w-1:0] mem_rdata;

    axi_wr_ctrl #(
        .mem_addr_w (mem_addr_w)
    ) u_wr_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb)
    );

    axi_rd_ctrl #(
        .mem_addr_w (mem_addr_w)
    ) u_rd_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    axi_ram_array #(
        .mem_addr_w (mem_addr_w)
    ) u_ram_array (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

endmodule

// ==== hdl/axi_rd_ctrl.sv ====
`timescale 1ns/10ps

module axi_rd_ctrl import axi_mem_pkg::*; #(
    parameter int mem_addr_w = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_ar_t               ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output axi_r_t                r,
    output logic                  r_valid,
    input  logic                  r_ready,
    output logic                  mem_re,
    output logic [mem_addr_w-3:0] mem_raddr,
    input  logic [axi_data_w-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait,
        st_hold
    } rd_state_e;

    rd_state_e             state;
    axi_ar_t               ar_q;       // addr field walks with the beats
    axi_r_t                r_q;
    logic [7:0]            beat_cnt;
    logic [axi_addr_w-1:0] next_addr;
    logic                  illegal;
    logic                  in_range;
    logic                  beat_ok;

    axi_burst_addr u_burst_addr (
        .addr      (ar_q.addr),
        .len       (ar_q.len),
        .size      (ar_q.size),
        .burst     (ar_q.burst),
        .next_addr (next_addr),
        .illegal   (illegal)
    );

    assign ar_ready  = (state == st_idle);
    assign r_valid   = (state == st_hold);
    assign mem_re    = (state == st_fetch);
    assign mem_raddr = ar_q.addr[mem_addr_w-1:2];

    assign in_range  = (ar_q.addr[axi_addr_w-1:mem_addr_w] == '0);
    assign beat_ok   = in_range && !illegal;

    assign r = r_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_valid) begin
                        state    <= st_fetch;
                        beat_cnt <= '0;
                    end
                end
                st_fetch: state <= st_wait;   // RAM read in flight
                st_wait: begin
                    state    <= st_hold;
                    beat_cnt <= beat_cnt + 8'd1;
                end
                st_hold: begin
                    if (r_ready) begin
                        state <= r_q.last ? st_idle : st_fetch;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Beat register frozen through st_hold
    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            ar_q <= ar;
        end else if (state == st_wait) begin
            r_q.id    <= ar_q.id;
            r_q.data  <= beat_ok ? mem_rdata : '0;
            r_q.resp  <= beat_ok ? resp_okay : resp_slverr;
            r_q.last  <= (beat_cnt == ar_q.len);
            ar_q.addr <= next_addr;
        end else if (state == st_hold && r_ready) begin
            r_q.last <= 1'b0;  // No stale last once the beat is taken
        end
    end

endmodule

// ==== hdl/axi_wr_ctrl.sv ====
`timescale 1ns/10ps

module axi_wr_ctrl import axi_mem_pkg::*; #(
    parameter int mem_addr_w = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_aw_t               aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_w_t                w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_b_t                b,
    output logic                  b_valid,
    input  logic                  b_ready,
    output logic                  mem_we,
    output logic [mem_addr_w-3:0] mem_waddr,
    output logic [axi_data_w-1:0] mem_wdata,
    output logic [axi_strb_w-1:0] mem_wstrb
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_resp
    } wr_state_e;

    wr_state_e             state;
    axi_aw_t               aw_q;       // addr field walks with the beats
    logic [7:0]            beat_cnt;
    logic                  err_q;
    logic [axi_addr_w-1:0] next_addr;
    logic                  illegal;
    logic                  in_range;
    logic                  beat_ok;
    logic                  last_beat;
    logic                  w_hs;
    logic [2:0]            nbytes;
    logic [1:0]            lane_lo;
    logic [2:0]            lane_hi;
    logic [axi_strb_w-1:0] lane_mask;

    axi_burst_addr u_burst_addr (
        .addr      (aw_q.addr),
        .len       (aw_q.len),
        .size      (aw_q.size),
        .burst     (aw_q.burst),
        .next_addr (next_addr),
        .illegal   (illegal)
    );

    assign aw_ready  = (state == st_idle);
    assign w_ready   = (state == st_data);
    assign b_valid   = (state == st_resp);
    assign b         = '{id: aw_q.id, resp: err_q ? resp_slverr : resp_okay};

    assign w_hs      = w_valid && w_ready;
    assign in_range  = (aw_q.addr[axi_addr_w-1:mem_addr_w] == '0);
    assign beat_ok   = in_range && !illegal;
    assign last_beat = (beat_cnt == aw_q.len);

    // Lanes covered by a narrow beat
    always_comb begin
        nbytes  = 3'd1 << aw_q.size[1:0];
        lane_lo = aw_q.addr[1:0];
        lane_hi = {1'b0, aw_q.addr[1:0] & ~(nbytes[1:0] - 2'd1)} + nbytes;
        for (int i = 0; i < axi_strb_w; i++) begin
            lane_mask[i] = (3'(i) >= {1'b0, lane_lo}) && (3'(i) < lane_hi);
        end
    end

    assign mem_we    = w_hs && beat_ok;
    assign mem_waddr = aw_q.addr[mem_addr_w-1:2];
    assign mem_wdata = w.data;
    assign mem_wstrb = w.strb & lane_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_valid) begin
                        state    <= st_data;
                        beat_cnt <= '0;
                        err_q    <= 1'b0;
                    end
                end
                st_data: begin
                    if (w_valid) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        // WLAST must agree with the beat count
                        if (!beat_ok || (w.last != last_beat)) begin
                            err_q <= 1'b1;
                        end
                        if (last_beat) begin
                            state <= st_resp;
                        end
                    end
                end
                st_resp: begin
                    if (b_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            aw_q <= aw;
        end else if (w_hs) begin
            aw_q.addr <= next_addr;
        end
    end

endmodule

// ==== hdl/axi_ram_array.sv ====
`timescale 1ns/10ps

module axi_ram_array import axi_mem_pkg::*; #(
    parameter int mem_addr_w = 12
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [mem_addr_w-3:0] waddr,
    input  logic [axi_data_w-1:0] wdata,
    input  logic [axi_strb_w-1:0] wstrb,
    input  logic                  re,
    input  logic [mem_addr_w-3:0] raddr,
    output logic [axi_data_w-1:0] rdata
);

    localparam int depth = 2 ** (mem_addr_w - 2);

    logic [axi_data_w-1:0] mem [depth];

    // Per-lane write enable
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < axi_strb_w; i++) begin
                if (wstrb[i]) begin
                    mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Old word wins on a same-cycle collision
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== hdl/axi_burst_addr.sv ====
`timescale 1ns/10ps

module axi_burst_addr import axi_mem_pkg::*; (
    input  logic [axi_addr_w-1:0] addr,
    input  logic [7:0]            len,
    input  logic [2:0]            size,
    input  burst_e                burst,
    output logic [axi_addr_w-1:0] next_addr,
    output logic                  illegal
);

    logic [axi_addr_w-1:0] nbytes;
    logic [axi_addr_w-1:0] aligned;
    logic [axi_addr_w-1:0] incr_addr;
    logic [axi_addr_w-1:0] wrap_mask;
    logic                  wrap_len_ok;

    assign nbytes    = axi_addr_w'(1) << size;
    assign aligned   = addr & ~(nbytes - axi_addr_w'(1));
    assign incr_addr = aligned + nbytes;

    // Window covers (len+1) beats of the transfer size
    assign wrap_mask = ((axi_addr_w'(len) + axi_addr_w'(1)) << size) - axi_addr_w'(1);

    always_comb begin
        case (len)
            8'd1, 8'd3, 8'd7, 8'd15: wrap_len_ok = 1'b1;
            default:                 wrap_len_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (burst)
            burst_incr: next_addr = incr_addr;
            burst_wrap: next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:    next_addr = addr;  // FIXED
        endcase
    end

    assign illegal = (size > axi_max_size) || ((burst == burst_wrap) && !wrap_len_ok);

endmodule

// ==== hdl/axi_mem_pkg.sv ====
package axi_mem_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_strb_w = axi_data_w / 8;
    localparam int axi_id_w   = 4;

    localparam logic [2:0] axi_max_size = 3'd2;  // 4 bytes, full bus width

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    typedef struct packed {
        logic [axi_id_w-1:0]   id;
        logic [axi_addr_w-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        burst_e                burst;
    } axi_aw_t;

    typedef struct packed {
        logic [axi_id_w-1:0]   id;
        logic [axi_addr_w-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        burst_e                burst;
    } axi_ar_t;

    typedef struct packed {
        logic [axi_data_w-1:0] data;
        logic [axi_strb_w-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        resp_e               resp;
    } axi_b_t;

    typedef struct packed {
        logic [axi_id_w-1:0]   id;
        logic [axi_data_w-1:0] data;
        resp_e                 resp;
        logic                  last;
    } axi_r_t;

endpackage
